//--- rtl/alu_pkg.sv
package alu_pkg;

	// opcode encoding of the ALU select field
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

	// flag bit positions in the EFLAGS word
	localparam int CF_BIT = 0;
	localparam int PF_BIT = 2;
	localparam int AF_BIT = 4;
	localparam int ZF_BIT = 6;
	localparam int SF_BIT = 7;
	localparam int DF_BIT = 10;
	localparam int OF_BIT = 11;

	localparam logic [31:0] FLAG_MASK = (32'd1 << CF_BIT) | (32'd1 << PF_BIT) |
		(32'd1 << AF_BIT) | (32'd1 << ZF_BIT) | (32'd1 << SF_BIT) |
		(32'd1 << DF_BIT) | (32'd1 << OF_BIT);

	// named view from the msb down
	typedef struct packed {
		logic [19:0] rsvd_31_12;
		logic        of;
		logic        df;
		logic [1:0]  rsvd_9_8;
		logic        sf;
		logic        zf;
		logic        rsvd_5;
		logic        af;
		logic        rsvd_3;
		logic        pf;
		logic        rsvd_1;
		logic        cf;
	} eflags_bits_t;

	typedef union packed {
		logic [31:0]  raw;
		eflags_bits_t bits;
	} eflags_u;

endpackage

//--- rtl/wb_pkg.sv
package wb_pkg;

	localparam int ADDR_W = 5;

	// word offsets of the register map
	localparam logic [ADDR_W-1:0] REG_A      = 5'h00;
	localparam logic [ADDR_W-1:0] REG_B      = 5'h04;
	localparam logic [ADDR_W-1:0] REG_OP     = 5'h08;
	localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;
	localparam logic [ADDR_W-1:0] REG_FLAGS  = 5'h10;
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h14;

	// status word layout
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;

endpackage

//--- rtl/alu_req_if.sv
`timescale 1ns/1ns

interface alu_req_if;

	// one-cycle launch strobe
	logic                 start;
	logic [31:0]          a;
	logic [31:0]          b;
	alu_pkg::alu_op_e     op;

	modport src (
		output start,
		output a,
		output b,
		output op
	);

	modport dst (
		input start,
		input a,
		input b,
		input op
	);

endinterface

//--- rtl/wb_alu_regs.sv
`timescale 1ns/1ns

module wb_alu_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [wb_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [31:0]                wb_dat_w,
	output logic [31:0]                wb_dat_r,
	output logic                       wb_ack,
	alu_req_if.src                     req,
	input  logic [31:0]                result,
	input  alu_pkg::eflags_u           flags,
	input  logic                       done,
	input  logic                       busy
);

	logic        access;
	logic        wr_en;
	logic [31:0] opa;
	logic [31:0] opb;
	logic [31:0] rd_data;

	// new access seen, ack not yet given
	assign access = wb_cyc & wb_stb & ~wb_ack;
	assign wr_en = access & wb_we;

	assign req.a = opa;
	assign req.b = opb;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			req.start <= 1'b0;
		end else begin
			wb_ack <= access;
			req.start <= wr_en && (wb_adr == wb_pkg::REG_OP);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wb_adr)
				wb_pkg::REG_A: opa <= wb_dat_w;
				wb_pkg::REG_B: opb <= wb_dat_w;
				wb_pkg::REG_OP: req.op <= alu_pkg::alu_op_e'(wb_dat_w[2:0]);
				// read-only offsets take the ack only
				default: ;
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			wb_pkg::REG_A: rd_data = opa;
			wb_pkg::REG_B: rd_data = opb;
			wb_pkg::REG_RESULT: rd_data = result;
			wb_pkg::REG_FLAGS: rd_data = flags.raw;
			wb_pkg::REG_STATUS: begin
				rd_data[wb_pkg::STATUS_DONE_BIT] = done;
				rd_data[wb_pkg::STATUS_BUSY_BIT] = busy;
			end
			default: rd_data = '0;
		endcase
	end

	// read data lines up with ack
	always_ff @(posedge clk) begin
		if (access)
			wb_dat_r <= rd_data;
	end

	a_ack_after_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb)
	);

endmodule

//--- rtl/alu_exec.sv
`timescale 1ns/1ns

module alu_exec (
	input  logic              clk,
	input  logic              rst_n,
	alu_req_if.dst            req,
	output logic              rsp_valid,
	output logic [31:0]       rsp_result,
	output alu_pkg::eflags_u  rsp_flags
);

	logic [32:0]       sum;
	logic [32:0]       diff;
	logic [4:0]        sum_lo;
	logic [4:0]        diff_lo;
	logic [31:0]       or_res;
	logic [31:0]       and_res;
	logic [4:0]        daa_lo;
	logic [4:0]        daa_hi;
	logic [7:0]        daa_byte;
	logic [31:0]       nxt_result;
	alu_pkg::eflags_u  nxt_flags;

	// bcd correction of one digit, carry in bit 4
	function automatic logic [4:0] daa_digit(input logic [3:0] d, input logic cin);
		logic [4:0] t;
		t = {1'b0, d} + {4'b0, cin};
		if (t > 5'd9)
			daa_digit = {1'b1, t[3:0] + 4'd6};
		else
			daa_digit = {1'b0, t[3:0]};
	endfunction

	// sf, zf, pf of a 32-bit result
	function automatic logic [2:0] szp(input logic [31:0] r);
		szp = {r[31], (r == 32'd0), ~^r[7:0]};
	endfunction

	assign sum = {1'b0, req.a} + {1'b0, req.b};
	assign diff = {1'b0, req.a} - {1'b0, req.b};
	assign sum_lo = {1'b0, req.a[3:0]} + {1'b0, req.b[3:0]};
	assign diff_lo = {1'b0, req.a[3:0]} - {1'b0, req.b[3:0]};
	assign or_res = req.a | req.b;
	assign and_res = req.a & req.b;

	assign daa_lo = daa_digit(req.a[3:0], 1'b0);
	assign daa_hi = daa_digit(req.a[7:4], daa_lo[4]);
	assign daa_byte = {daa_hi[3:0], daa_lo[3:0]};

	always_comb begin
		nxt_result = '0;
		nxt_flags.raw = '0;
		case (req.op)
			alu_pkg::OP_ADD: begin
				nxt_result = sum[31:0];
				nxt_flags.bits.cf = sum[32];
				nxt_flags.bits.af = sum_lo[4];
				nxt_flags.bits.of = (req.a[31] == req.b[31]) && (sum[31] != req.a[31]);
				{nxt_flags.bits.sf, nxt_flags.bits.zf, nxt_flags.bits.pf} = szp(sum[31:0]);
			end
			alu_pkg::OP_OR: begin
				nxt_result = or_res;
				{nxt_flags.bits.sf, nxt_flags.bits.zf, nxt_flags.bits.pf} = szp(or_res);
			end
			alu_pkg::OP_NOT: begin
				nxt_result = ~req.a;
			end
			alu_pkg::OP_DAA: begin
				nxt_result = {24'd0, daa_byte};
				nxt_flags.bits.af = daa_lo[4] | daa_hi[4];
				nxt_flags.bits.cf = daa_lo[4] | daa_hi[4];
				nxt_flags.bits.zf = (daa_byte == 8'd0);
				nxt_flags.bits.pf = ~^daa_byte;
			end
			alu_pkg::OP_AND: begin
				nxt_result = and_res;
				{nxt_flags.bits.sf, nxt_flags.bits.zf, nxt_flags.bits.pf} = szp(and_res);
			end
			alu_pkg::OP_CLD: begin
				nxt_flags.bits.df = 1'b0;
			end
			alu_pkg::OP_CMP: begin
				// flags only, difference is dropped
				nxt_flags.bits.cf = diff[32];
				nxt_flags.bits.af = diff_lo[4];
				nxt_flags.bits.of = (req.a[31] != req.b[31]) && (diff[31] != req.a[31]);
				{nxt_flags.bits.sf, nxt_flags.bits.zf, nxt_flags.bits.pf} = szp(diff[31:0]);
			end
			alu_pkg::OP_STD: begin
				nxt_flags.bits.df = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= req.start;
	end

	always_ff @(posedge clk) begin
		if (req.start) begin
			rsp_result <= nxt_result;
			rsp_flags <= nxt_flags;
		end
	end

	a_flags_in_mask: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> ((rsp_flags.raw & ~alu_pkg::FLAG_MASK) == 32'd0)
	);

	a_valid_after_start: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> $past(req.start)
	);

endmodule

//--- rtl/alu_result_regs.sv
`timescale 1ns/1ns

module alu_result_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic              rsp_valid,
	input  logic [31:0]       rsp_result,
	input  alu_pkg::eflags_u  rsp_flags,
	output logic [31:0]       result,
	output alu_pkg::eflags_u  flags,
	output logic              done,
	output logic              busy
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
			flags.raw <= '0;
		end else if (rsp_valid) begin
			result <= rsp_result;
			flags.raw <= rsp_flags.raw;
		end
	end

	// a new launch wins over a landing result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
			busy <= 1'b0;
		end else if (start) begin
			done <= 1'b0;
			busy <= 1'b1;
		end else if (rsp_valid) begin
			done <= 1'b1;
			busy <= 1'b0;
		end
	end

	a_done_busy_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(done && busy)
	);

endmodule

//--- rtl/alu_top.sv
`timescale 1ns/1ns

module alu_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [wb_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [31:0]                wb_dat_w,
	output logic [31:0]                wb_dat_r,
	output logic                       wb_ack
);

	logic              rsp_valid;
	logic [31:0]       rsp_result;
	alu_pkg::eflags_u  rsp_flags;
	logic [31:0]       result;
	alu_pkg::eflags_u  flags;
	logic              done;
	logic              busy;

	alu_req_if req_if ();

	wb_alu_regs u_wb_alu_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.req      (req_if.src),
		.result   (result),
		.flags    (flags),
		.done     (done),
		.busy     (busy)
	);

	alu_exec u_alu_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req_if.dst),
		.rsp_valid  (rsp_valid),
		.rsp_result (rsp_result),
		.rsp_flags  (rsp_flags)
	);

	alu_result_regs u_alu_result_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (req_if.start),
		.rsp_valid  (rsp_valid),
		.rsp_result (rsp_result),
		.rsp_flags  (rsp_flags),
		.result     (result),
		.flags      (flags),
		.done       (done),
		.busy       (busy)
	);

endmodule

//--- tb/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

localparam longint INT32_MAX = 64'sd2147483647;
localparam longint INT32_MIN = -64'sd2147483648;

// even parity over bits 7..0
function automatic logic low_byte_parity(input logic [31:0] r);
	int ones;
	ones = 0;
	for (int i = 0; i < 8; i++) begin
		if (r[i])
			ones++;
	end
	return (ones % 2) == 0;
endfunction

// true signed result outside the 32-bit range
function automatic logic signed_overflows(input logic [31:0] a, input logic [31:0] b,
		input logic subtract);
	longint s;
	if (subtract)
		s = longint'($signed(a)) - longint'($signed(b));
	else
		s = longint'($signed(a)) + longint'($signed(b));
	return (s > INT32_MAX) || (s < INT32_MIN);
endfunction

function automatic logic [31:0] szp_bits(input logic [31:0] r);
	logic [31:0] f;
	f = '0;
	f[alu_pkg::SF_BIT] = r[31];
	f[alu_pkg::ZF_BIT] = (r == 32'd0);
	f[alu_pkg::PF_BIT] = low_byte_parity(r);
	return f;
endfunction

// decimal adjust of one byte, carry on top
function automatic logic [8:0] daa_model(input logic [7:0] v);
	logic [7:0] lo;
	logic [7:0] hi;
	logic       c1;
	logic       c2;
	lo = {4'd0, v[3:0]};
	c1 = lo > 8'd9;
	if (c1)
		lo = (lo + 8'd6) & 8'h0f;
	hi = {4'd0, v[7:4]} + {7'd0, c1};
	c2 = hi > 8'd9;
	if (c2)
		hi = (hi + 8'd6) & 8'h0f;
	return {c1 | c2, hi[3:0], lo[3:0]};
endfunction

function automatic logic [31:0] model_result(input logic [2:0] op, input logic [31:0] a,
		input logic [31:0] b);
	logic [8:0] d;
	d = daa_model(a[7:0]);
	case (op)
		alu_pkg::OP_ADD: return a + b;
		alu_pkg::OP_OR:  return a | b;
		alu_pkg::OP_NOT: return ~a;
		alu_pkg::OP_DAA: return {24'd0, d[7:0]};
		alu_pkg::OP_AND: return a & b;
		default:         return 32'd0;
	endcase
endfunction

function automatic logic [31:0] model_flags(input logic [2:0] op, input logic [31:0] a,
		input logic [31:0] b);
	logic [31:0] f;
	logic [31:0] r;
	logic [8:0]  d;
	f = '0;
	case (op)
		alu_pkg::OP_ADD: begin
			r = a + b;
			f = szp_bits(r);
			// wrapped sum is smaller than an addend on carry out
			f[alu_pkg::CF_BIT] = r < a;
			f[alu_pkg::AF_BIT] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
			f[alu_pkg::OF_BIT] = signed_overflows(a, b, 1'b0);
		end
		alu_pkg::OP_OR:  f = szp_bits(a | b);
		alu_pkg::OP_AND: f = szp_bits(a & b);
		alu_pkg::OP_DAA: begin
			d = daa_model(a[7:0]);
			f[alu_pkg::CF_BIT] = d[8];
			f[alu_pkg::AF_BIT] = d[8];
			f[alu_pkg::ZF_BIT] = (d[7:0] == 8'd0);
			f[alu_pkg::PF_BIT] = low_byte_parity({24'd0, d[7:0]});
		end
		alu_pkg::OP_CMP: begin
			f = szp_bits(a - b);
			f[alu_pkg::CF_BIT] = a < b;
			f[alu_pkg::AF_BIT] = a[3:0] < b[3:0];
			f[alu_pkg::OF_BIT] = signed_overflows(a, b, 1'b1);
		end
		alu_pkg::OP_STD: f[alu_pkg::DF_BIT] = 1'b1;
		default: f = '0;
	endcase
	return f & alu_pkg::FLAG_MASK;
endfunction

`endif

//--- tb/tb_alu_top.sv
`timescale 1ns/1ns

module tb_alu_top;

	localparam int ACK_TIMEOUT = 16;
	localparam int DONE_POLLS = 20;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [4:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	int          errors;
	int          timeouts;

	`include "alu_ref_model.svh"

	alu_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #4 clk = ~clk;

	// one classic cycle entered and left on a falling edge
	task automatic bus_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int   cycles;
		logic got_ack;
		cycles = 0;
		got_ack = 1'b0;
		rdata = '0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		while (!got_ack && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (wb_ack) begin
				got_ack = 1'b1;
				rdata = wb_dat_r;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!got_ack) begin
			timeouts++;
			$display("Bus slave gave no ack for offset 0x%02h within %0d cycles", adr,
				ACK_TIMEOUT);
		end
	endtask

	task automatic bus_write(input logic [4:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic bus_read(input logic [4:0] adr, output logic [31:0] data);
		bus_access(1'b0, adr, 32'd0, data);
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("Error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// exactly one of busy and done
	task automatic check_status_after_launch();
		logic [31:0] st;
		bus_read(wb_pkg::REG_STATUS, st);
		assert (st == (32'd1 << wb_pkg::STATUS_DONE_BIT) ||
				st == (32'd1 << wb_pkg::STATUS_BUSY_BIT)) else begin
			errors++;
			$display("Error at %0t ns: status 0x%08h after launch, expected busy or done alone",
				$time, st);
		end
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int          polls;
		logic        seen;
		polls = 0;
		seen = 1'b0;
		while (!seen && polls < DONE_POLLS) begin
			bus_read(wb_pkg::REG_STATUS, st);
			polls++;
			seen = st[wb_pkg::STATUS_DONE_BIT];
		end
		if (!seen) begin
			timeouts++;
			$display("Operation never reported done within %0d status polls", DONE_POLLS);
		end
	endtask

	task automatic check_outputs(input logic [2:0] op, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] rd;
		bus_read(wb_pkg::REG_RESULT, rd);
		check_word($sformatf("result of op %0d", op), rd, model_result(op, a, b));
		bus_read(wb_pkg::REG_FLAGS, rd);
		check_word($sformatf("flags of op %0d", op), rd, model_flags(op, a, b));
	endtask

	task automatic run_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
		bus_write(wb_pkg::REG_A, a);
		bus_write(wb_pkg::REG_B, b);
		bus_write(wb_pkg::REG_OP, {29'd0, op});
		check_status_after_launch();
		wait_done();
		check_outputs(op, a, b);
	endtask

	// half fully random and half corner values
	function automatic logic [31:0] pick_operand();
		logic [31:0] v;
		if ($urandom % 2 == 0)
			return $urandom;
		case ($urandom % 5)
			0: v = 32'h0000_0000;
			1: v = 32'hffff_ffff;
			2: v = 32'h7fff_ffff;
			3: v = 32'h8000_0000;
			default: v = {24'd0, 4'($urandom % 10), 4'($urandom % 10)};
		endcase
		return v;
	endfunction

	initial begin
		logic [31:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] a2;
		logic [31:0] b2;
		logic [2:0]  op;
		logic [2:0]  op2;
		errors = 0;
		timeouts = 0;
		void'($urandom(74972));
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		bus_read(wb_pkg::REG_RESULT, rd);
		check_word("result after reset", rd, 32'd0);
		bus_read(wb_pkg::REG_FLAGS, rd);
		check_word("flags after reset", rd, 32'd0);
		bus_read(wb_pkg::REG_STATUS, rd);
		check_word("status after reset", rd, 32'd0);

		for (int i = 0; i < 400; i++) begin
			a = pick_operand();
			b = pick_operand();
			op = 3'($urandom % 8);
			run_op(op, a, b);
		end

		// new operands written while the previous launch is in flight
		for (int i = 0; i < 20; i++) begin
			a = pick_operand();
			b = pick_operand();
			op = 3'($urandom % 8);
			a2 = $urandom;
			b2 = $urandom;
			bus_write(wb_pkg::REG_A, a);
			bus_write(wb_pkg::REG_B, b);
			bus_write(wb_pkg::REG_OP, {29'd0, op});
			bus_write(wb_pkg::REG_A, a2);
			bus_write(wb_pkg::REG_B, b2);
			bus_read(wb_pkg::REG_A, rd);
			check_word("operand A readback", rd, a2);
			bus_read(wb_pkg::REG_B, rd);
			check_word("operand B readback", rd, b2);
			wait_done();
			check_outputs(op, a, b);
		end

		// back-to-back launches where the second one wins
		for (int i = 0; i < 20; i++) begin
			a = pick_operand();
			b = pick_operand();
			op = 3'($urandom % 8);
			op2 = 3'($urandom % 8);
			bus_write(wb_pkg::REG_A, a);
			bus_write(wb_pkg::REG_B, b);
			bus_write(wb_pkg::REG_OP, {29'd0, op});
			if (i % 2 == 0) begin
				a2 = pick_operand();
				bus_write(wb_pkg::REG_A, a2);
			end else begin
				a2 = a;
			end
			bus_write(wb_pkg::REG_OP, {29'd0, op2});
			wait_done();
			check_outputs(op2, a2, b);
		end

		// result register is read only
		for (int i = 0; i < 10; i++) begin
			a = pick_operand();
			b = pick_operand();
			op = 3'($urandom % 8);
			run_op(op, a, b);
			bus_write(wb_pkg::REG_RESULT, $urandom);
			bus_read(wb_pkg::REG_RESULT, rd);
			check_word("result after write attempt", rd, model_result(op, a, b));
		end

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+tb
rtl/alu_pkg.sv
rtl/wb_pkg.sv
rtl/alu_req_if.sv
rtl/wb_alu_regs.sv
rtl/alu_exec.sv
rtl/alu_result_regs.sv
rtl/alu_top.sv
tb/tb_alu_top.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_alu_top \
	&& ./obj_dir/Vtb_alu_top > sim.log 2>&1 \
	|| echo "build or simulation step returned an error"
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log 2>/dev/null && exit 0 || exit 1
